// File: design/branch_compare.sv
`timescale 1ns/1ps

module branch_compare
	import rv_isa_pkg::*, obs_pkg::*;
(
	input instr_class_t cls_i,
	input xlen_word_t rs1_data_i,
	input xlen_word_t rs2_data_i,
	output logic taken_o
);

	logic [XLEN:0] sub_a;
	logic [XLEN:0] sub_b;
	logic [XLEN:0] sub_sum;
	xlen_word_t diff;
	logic is_equal;
	logic is_signed;
	logic is_ge;

	// rs1 - rs2 as rs1 + ~rs2 + 1
	// the low ones supply the +1
	assign sub_a = {rs1_data_i, 1'b1};
	assign sub_b = {rs2_data_i, 1'b0} ^ {(XLEN + 1){1'b1}};
	assign sub_sum = sub_a + sub_b;
	assign diff = sub_sum[XLEN:1];

	assign is_equal = (diff == '0);
	assign is_signed = (cls_i.cmp_op == LT) || (cls_i.cmp_op == GE);

	// equal signs: no overflow, sign of the difference decides
	// different signs: rs1 sign alone decides
	always_comb begin
		if (rs1_data_i[XLEN-1] == rs2_data_i[XLEN-1]) begin
			is_ge = ~diff[XLEN-1];
		end else begin
			is_ge = rs1_data_i[XLEN-1] ^ is_signed;
		end
	end

	// valid for any word, is_branch qualifies it downstream
	always_comb begin
		case (cls_i.cmp_op)
			EQ: taken_o = is_equal;
			NE: taken_o = ~is_equal;
			GE, GEU: taken_o = is_ge;
			LT, LTU: taken_o = ~is_ge;
			default: taken_o = is_equal;
		endcase
	end

endmodule

// File: design/contract_observer_top.sv
`timescale 1ns/1ps

module contract_observer_top
	import rv_isa_pkg::*, obs_pkg::*;
(
	input logic clk_i,
	input logic arst_n_i,
	input retire_in_t retire_i,
	input instr_word_u instr_i,
	input xlen_word_t rs1_data_i,
	input xlen_word_t rs2_data_i,
	output obs_result_t obs_o
);

	retire_obs_t cap;
	instr_class_t cls;
	xlen_word_t lsu_addr;
	logic split;
	logic taken;

	// capture stage, the only state
	retire_capture u_capture (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.retire_i(retire_i),
		.cap_o(cap)
	);

	// analysis stage, purely combinational
	instr_classifier u_classifier (
		.instr_i(instr_i),
		.cls_o(cls)
	);

	mem_access_observer u_mem_obs (
		.cls_i(cls),
		.rs1_data_i(rs1_data_i),
		.last_addr_i(cap.last_addr),
		.lsu_addr_o(lsu_addr),
		.split_o(split)
	);

	branch_compare u_branch_cmp (
		.cls_i(cls),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.taken_o(taken)
	);

	assign obs_o.pc = cap.pc;
	assign obs_o.rs1_idx = cls.rs1_idx;
	assign obs_o.rs2_idx = cls.rs2_idx;
	assign obs_o.lsu_addr = lsu_addr;
	assign obs_o.split_access = split;
	assign obs_o.is_load = cls.is_load;
	assign obs_o.is_store = cls.is_store;
	assign obs_o.is_branch = cls.is_branch;
	assign obs_o.cmp_taken = taken;

endmodule

// File: design/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier
	import rv_isa_pkg::*, obs_pkg::*;
(
	input instr_word_u instr_i,
	output instr_class_t cls_o
);

	logic is_load;
	logic is_store;
	access_size_e size;
	cmp_op_e cmp_op;
	xlen_word_t imm_i;
	xlen_word_t imm_s;

	// funct3 sits at the same bits in both views
	assign is_load = (instr_i.i_view.opcode == OPC_LOAD);
	assign is_store = (instr_i.s_view.opcode == OPC_STORE);

	// size from funct3 low bits, sign bit ignored
	always_comb begin
		case (instr_i.i_view.funct3[1:0])
			2'b00: size = BYTE;
			2'b01: size = HALF;
			default: size = WORD;
		endcase
	end

	// 010 and 011 are not branches, treat as equality
	always_comb begin
		case (instr_i.i_view.funct3)
			F3_BEQ: cmp_op = EQ;
			F3_BNE: cmp_op = NE;
			F3_BLT: cmp_op = LT;
			F3_BGE: cmp_op = GE;
			F3_BLTU: cmp_op = LTU;
			F3_BGEU: cmp_op = GEU;
			default: cmp_op = EQ;
		endcase
	end

	// sign-extended immediates of both formats
	assign imm_i = {{20{instr_i.i_view.imm[11]}}, instr_i.i_view.imm};
	assign imm_s = {{20{instr_i.s_view.imm_hi[6]}}, instr_i.s_view.imm_hi,
		instr_i.s_view.imm_lo};

	always_comb begin
		cls_o.is_load = is_load;
		cls_o.is_store = is_store;
		cls_o.is_branch = (instr_i.i_view.opcode == OPC_BRANCH);
		cls_o.size = size;
		cls_o.cmp_op = cmp_op;
		if (is_load) begin
			cls_o.imm = imm_i;
		end else if (is_store) begin
			cls_o.imm = imm_s;
		end else begin
			cls_o.imm = '0;
		end
		// rs1 at 19:15, rs2 at 24:20
		cls_o.rs1_idx = instr_i.i_view.rs1;
		cls_o.rs2_idx = instr_i.s_view.rs2;
	end

endmodule

// File: design/mem_access_observer.sv
`timescale 1ns/1ps

module mem_access_observer
	import rv_isa_pkg::*, obs_pkg::*;
(
	input instr_class_t cls_i,
	input xlen_word_t rs1_data_i,
	input xlen_word_t last_addr_i,
	output xlen_word_t lsu_addr_o,
	output logic split_o
);

	logic [XLEN:0] adder_a;
	logic [XLEN:0] adder_b;
	logic [XLEN:0] adder_sum;
	logic [WORD_OFFSET_W-1:0] offset;

	// same extended adder shape as the core alu
	// bit 0 is the carry-in slot, zero here
	assign adder_a = {rs1_data_i, 1'b1};
	assign adder_b = {cls_i.imm, 1'b0};
	assign adder_sum = adder_a + adder_b;
	assign lsu_addr_o = adder_sum[XLEN:1];

	// offset of the previously retired access, not the current one
	assign offset = last_addr_i[WORD_OFFSET_W-1:0];

	// would need a second bus transaction
	always_comb begin
		case (cls_i.size)
			WORD: split_o = (offset != '0);
			HALF: split_o = (offset == {WORD_OFFSET_W{1'b1}});
			default: split_o = 1'b0;
		endcase
	end

endmodule

// File: design/obs_pkg.sv
package obs_pkg;

	import rv_isa_pkg::*;

	// byte offset inside a 32-bit word
	localparam int unsigned WORD_OFFSET_W = 2;

	// same numbering as the core lsu type
	typedef enum logic [1:0] {WORD = 2'b00, HALF = 2'b01, BYTE = 2'b10} access_size_e;

	typedef enum logic [2:0] {EQ, NE, LT, GE, LTU, GEU} cmp_op_e;

	// retire strobe plus values sampled from the core
	typedef struct packed {
		logic valid;
		xlen_word_t pc;
		xlen_word_t adder_addr;
	} retire_in_t;

	// state latched at retirement
	typedef struct packed {
		xlen_word_t pc;
		xlen_word_t last_addr;
	} retire_obs_t;

	typedef struct packed {
		logic is_load;
		logic is_store;
		logic is_branch;
		access_size_e size;
		cmp_op_e cmp_op;
		xlen_word_t imm;
		reg_idx_t rs1_idx;
		reg_idx_t rs2_idx;
	} instr_class_t;

	typedef struct packed {
		xlen_word_t pc;
		reg_idx_t rs1_idx;
		reg_idx_t rs2_idx;
		xlen_word_t lsu_addr;
		logic split_access;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic cmp_taken;
	} obs_result_t;

endpackage

// File: design/retire_capture.sv
`timescale 1ns/1ps

module retire_capture
	import obs_pkg::*;
(
	input logic clk_i,
	input logic arst_n_i,
	input retire_in_t retire_i,
	output retire_obs_t cap_o
);

	// pc and address of the last retired instruction
	// both hold until the next strobe
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cap_o <= '0;
		end else if (retire_i.valid) begin
			cap_o.pc <= retire_i.pc;
			cap_o.last_addr <= retire_i.adder_addr;
		end
	end

endmodule

// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int unsigned XLEN = 32;

	typedef logic [XLEN-1:0] xlen_word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;

	// major opcodes of interest
	localparam opcode_t OPC_LOAD = 7'h03;
	localparam opcode_t OPC_STORE = 7'h23;
	localparam opcode_t OPC_BRANCH = 7'h63;

	// branch funct3 codes
	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;
	localparam funct3_t F3_BLT = 3'b100;
	localparam funct3_t F3_BGE = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// i-type layout, used by loads
	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t rs1;
		funct3_t funct3;
		reg_idx_t rd;
		opcode_t opcode;
	} instr_i_t;

	// s-type layout, used by stores
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t rs2;
		reg_idx_t rs1;
		funct3_t funct3;
		logic [4:0] imm_lo;
		opcode_t opcode;
	} instr_s_t;

	// one instruction word, two field layouts
	typedef union packed {
		instr_i_t i_view;
		instr_s_t s_view;
	} instr_word_u;

endpackage

// File: project.f
design/rv_isa_pkg.sv
design/obs_pkg.sv
design/retire_capture.sv
design/instr_classifier.sv
design/mem_access_observer.sv
design/branch_compare.sv
design/contract_observer_top.sv
tests/contract_observer_chk.sv
tests/contract_observer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the observer testbench with verilator and run it

LOG=sim.log
BIN=obj_dir/Vcontract_observer_tb

rm -f "$LOG"

# a failed build or an aborted run is logged as a failure
verilator --binary --assert --top-module contract_observer_tb -f project.f > "$LOG" 2>&1 \
	&& "$BIN" >> "$LOG" 2>&1 \
	|| echo "Simulation FAILED" >> "$LOG"

cat "$LOG"

grep -q "Simulation FAILED" "$LOG" && exit 1
exit 0

// File: tests/contract_observer_chk.sv
`timescale 1ns/1ps

module contract_observer_chk
	import obs_pkg::*;
(
	input logic clk_i,
	input logic arst_n_i,
	input retire_in_t retire_i,
	input obs_result_t obs_o
);

	int unsigned fail_count = 0;

	// opcodes are distinct, so classes are exclusive
	a_one_class: assert property (@(posedge clk_i)
		$onehot0({obs_o.is_load, obs_o.is_store, obs_o.is_branch}))
	else begin
		$error("more than one instruction class flag set");
		fail_count++;
	end

	a_reset_pc: assert property (@(posedge clk_i) !arst_n_i |-> obs_o.pc == '0)
	else begin
		$error("captured pc not zero during reset");
		fail_count++;
	end

	// no strobe, no update
	a_pc_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!retire_i.valid |=> $stable(obs_o.pc))
	else begin
		$error("captured pc changed without a retire strobe");
		fail_count++;
	end

endmodule

bind contract_observer_top contract_observer_chk u_chk (
	.clk_i(clk_i),
	.arst_n_i(arst_n_i),
	.retire_i(retire_i),
	.obs_o(obs_o)
);

// File: tests/contract_observer_tb.sv
`timescale 1ns/1ps

module contract_observer_tb
	import rv_isa_pkg::*, obs_pkg::*;
();

	localparam int unsigned RESET_CYCLES = 16;
	localparam int unsigned CAPTURE_N = 8;
	localparam int unsigned CLASS_N = 200;
	localparam int unsigned ADDR_N = 200;
	localparam int unsigned SPLIT_N = 4 * 9;
	localparam int unsigned BRANCH_PER_OP = 20;
	localparam int unsigned CYCLE_LIMIT = RESET_CYCLES + CAPTURE_N + CLASS_N + ADDR_N
		+ SPLIT_N + 8 * BRANCH_PER_OP + 100;

	// slot 0 is replaced by a random value paired with itself
	localparam xlen_word_t EDGE_A [8] = '{32'h0000_0000, 32'h0000_0000, 32'h8000_0000,
		32'h7fff_ffff, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h8000_0000};
	localparam xlen_word_t EDGE_B [8] = '{32'h0000_0000, 32'h0000_0000, 32'h7fff_ffff,
		32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};

	logic clk_i;
	logic arst_n_i;
	retire_in_t retire_i;
	instr_word_u instr_i;
	xlen_word_t rs1_data_i;
	xlen_word_t rs2_data_i;
	obs_result_t obs_o;

	xlen_word_t lcg_state = 32'h6862_8d07;
	xlen_word_t model_pc = '0;
	xlen_word_t model_addr = '0;
	string cur_test = "none";
	int unsigned cycle_cnt = 0;
	int unsigned test_errs = 0;
	int unsigned total_errs = 0;
	int unsigned check_cnt = 0;
	int unsigned tests_run = 0;
	int unsigned tests_failed = 0;

	contract_observer_top u_dut (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.retire_i(retire_i),
		.instr_i(instr_i),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.obs_o(obs_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic xlen_word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// sign-extended I immediate for loads, S immediate for stores
	function automatic xlen_word_t model_imm(input xlen_word_t w);
		if (w[6:0] == OPC_LOAD) begin
			return {{20{w[31]}}, w[31:20]};
		end else if (w[6:0] == OPC_STORE) begin
			return {{20{w[31]}}, w[31:25], w[11:7]};
		end
		return '0;
	endfunction

	function automatic logic model_split(input xlen_word_t w, input xlen_word_t last);
		logic [1:0] off;
		off = last[1:0];
		case (w[13:12])
			2'b00: return 1'b0;
			2'b01: return (off == 2'b11);
			default: return (off != 2'b00);
		endcase
	endfunction

	// unlisted funct3 codes behave as beq
	function automatic logic model_taken(input xlen_word_t w, input xlen_word_t a,
		input xlen_word_t b);
		case (w[14:12])
			F3_BNE: return (a != b);
			F3_BLT: return ($signed(a) < $signed(b));
			F3_BGE: return ($signed(a) >= $signed(b));
			F3_BLTU: return (a < b);
			F3_BGEU: return (a >= b);
			default: return (a == b);
		endcase
	endfunction

	// low two sel bits force a load, store or branch opcode or keep base
	function automatic xlen_word_t biased_word(input xlen_word_t sel, input xlen_word_t base);
		case (sel[1:0])
			2'b00: return {base[31:7], OPC_LOAD};
			2'b01: return {base[31:7], OPC_STORE};
			2'b10: return {base[31:7], OPC_BRANCH};
			default: return base;
		endcase
	endfunction

	task automatic check_word(input string field, input xlen_word_t exp_val,
		input xlen_word_t act_val);
		check_cnt++;
		if (act_val !== exp_val) begin
			$display("MISMATCH %s %s: expected %h actual %h", cur_test, field, exp_val, act_val);
			test_errs++;
		end
	endtask

	task automatic check_idx(input string field, input reg_idx_t exp_val,
		input reg_idx_t act_val);
		check_cnt++;
		if (act_val !== exp_val) begin
			$display("MISMATCH %s %s: expected %0d actual %0d", cur_test, field, exp_val,
				act_val);
			test_errs++;
		end
	endtask

	task automatic check_flag(input string field, input logic exp_val, input logic act_val);
		check_cnt++;
		if (act_val !== exp_val) begin
			$display("MISMATCH %s %s: expected %b actual %b", cur_test, field, exp_val, act_val);
			test_errs++;
		end
	endtask

	task automatic check_outputs();
		xlen_word_t w;
		w = instr_i;
		check_word("pc", model_pc, obs_o.pc);
		check_idx("rs1_idx", w[19:15], obs_o.rs1_idx);
		check_idx("rs2_idx", w[24:20], obs_o.rs2_idx);
		check_word("lsu_addr", rs1_data_i + model_imm(w), obs_o.lsu_addr);
		check_flag("split_access", model_split(w, model_addr), obs_o.split_access);
		check_flag("is_load", w[6:0] == OPC_LOAD, obs_o.is_load);
		check_flag("is_store", w[6:0] == OPC_STORE, obs_o.is_store);
		check_flag("is_branch", w[6:0] == OPC_BRANCH, obs_o.is_branch);
		check_flag("cmp_taken", model_taken(w, rs1_data_i, rs2_data_i), obs_o.cmp_taken);
	endtask

	// model update at the edge, then drive at +1 ns and check mid-cycle
	task automatic apply(input logic valid, input xlen_word_t pc, input xlen_word_t addr,
		input xlen_word_t word, input xlen_word_t rs1, input xlen_word_t rs2);
		@(posedge clk_i);
		if (arst_n_i && retire_i.valid) begin
			model_pc = retire_i.pc;
			model_addr = retire_i.adder_addr;
		end
		#1;
		retire_i.valid = valid;
		retire_i.pc = pc;
		retire_i.adder_addr = addr;
		instr_i = word;
		rs1_data_i = rs1;
		rs2_data_i = rs2;
		#4;
		check_outputs();
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		$display("test %-14s checks so far %0d, errors %0d", cur_test, check_cnt, test_errs);
		tests_run++;
		total_errs += test_errs;
		if (test_errs != 0) begin
			tests_failed++;
		end
	endtask

	initial begin
		xlen_word_t w;
		xlen_word_t sel;
		xlen_word_t addr;
		xlen_word_t a;
		xlen_word_t b;

		arst_n_i = 1'b0;
		retire_i = '0;
		instr_i = '0;
		rs1_data_i = '0;
		rs2_data_i = '0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1;
		arst_n_i = 1'b1;

		// two strobes with quiet cycles between them
		begin_test("reset_capture");
		for (int i = 0; i < CAPTURE_N; i++) begin
			apply(i == 1 || i == 5, next_rand(), next_rand(), next_rand(), next_rand(),
				next_rand());
		end
		end_test();

		// low lcg bits repeat quickly so selectors come from the upper half
		begin_test("classify");
		for (int i = 0; i < CLASS_N; i++) begin
			sel = next_rand() >> 16;
			w = biased_word(sel, next_rand());
			apply(sel[2], next_rand(), next_rand(), w, next_rand(), next_rand());
		end
		end_test();

		begin_test("eff_address");
		for (int i = 0; i < ADDR_N; i++) begin
			sel = next_rand() >> 16;
			w = biased_word({sel[31:2], 1'b0, sel[0]}, next_rand());
			if (sel[1]) begin
				w = next_rand();
			end
			apply(sel[3], next_rand(), next_rand(), w, next_rand(), next_rand());
		end
		end_test();

		// every size as load and store after each retired offset
		begin_test("split_access");
		for (int off = 0; off < 4; off++) begin
			addr = next_rand();
			addr[1:0] = off[1:0];
			apply(1'b1, next_rand(), addr, next_rand(), next_rand(), next_rand());
			for (int k = 0; k < 8; k++) begin
				w = next_rand();
				w[13:12] = k[1:0];
				w[6:0] = k[2] ? OPC_STORE : OPC_LOAD;
				apply(1'b0, next_rand(), next_rand(), w, next_rand(), next_rand());
			end
		end
		end_test();

		begin_test("branch_compare");
		for (int f3 = 0; f3 < 8; f3++) begin
			for (int k = 0; k < BRANCH_PER_OP; k++) begin
				w = next_rand();
				w[14:12] = f3[2:0];
				w[6:0] = OPC_BRANCH;
				a = next_rand();
				b = next_rand();
				if (k == 0) begin
					b = a;
				end else if (k < 8) begin
					a = EDGE_A[k];
					b = EDGE_B[k];
				end
				apply(1'b0, next_rand(), next_rand(), w, a, b);
			end
		end
		end_test();

		if (u_dut.u_chk.fail_count != 0) begin
			$display("checker reported %0d assertion failures", u_dut.u_chk.fail_count);
		end
		$display("tests %0d, failed %0d, checks %0d, mismatches %0d", tests_run,
			tests_failed, check_cnt, total_errs);
		if (tests_failed == 0 && total_errs == 0 && u_dut.u_chk.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
